//--- bench/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// LCG step, 32-bit state
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// Expected FIFO words for one run, from the planned sample stream
function automatic void build_expected(input logic [CHAN_W-1:0] first_chan,
                                       input int nch, input int size);
    int                idx;
    int                frame_cnt;
    int                n;
    logic [WORD_W-1:0] w;
    logic [CHAN_W-1:0] ch;
    logic              eod;

    idx       = 0;
    frame_cnt = 0;
    exp_word_q.delete();
    exp_len_q.delete();
    exp_eod_q.delete();
    for (int c = 0; c < nch; c++)
    begin
        ch = first_chan + CHAN_W'(c);
        for (int s = 0; s < size; s += 5)
        begin
            n = (size - s < 5) ? size - s : 5;
            w = '0;
            for (int k = 0; k < n; k++)
                w[k*12 +: 12] = sample_q[idx + k];
            w[63:60] = {1'b0, ch};          // Channel tag
            idx       = idx + n;
            frame_cnt = frame_cnt + 1;
            eod = (s + n == size) || (frame_cnt == MAX_WORDS_PER_FRAME);
            exp_word_q.push_back(w);
            exp_len_q.push_back(PKT_LEN_W'(frame_cnt));
            exp_eod_q.push_back(eod);
            if (eod)
                frame_cnt = 0;
        end
    end
endfunction

`endif

//--- bench/tb_xadc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xadc_capture import xadc_pkg::*; ();

    // Worst case cycles per test, summed over the five runs
    localparam int TIMEOUT_CYCLES = 7*(3+14) + 200 + 24*(2+14) + 200
                                  + 760*(2+14) + 200 + 6*(20+14) + 200 + 2*(1+14) + 200;

    logic                  clk200;
    logic                  rst;
    logic                  data_in_rdy;
    logic [VMM_ID_W-1:0]   vmm_id;
    logic [COUNT_W-1:0]    sample_size;
    logic [DELAY_W-1:0]    delay_in;
    logic                  udp_done;
    logic                  adc_done;
    logic [SAMPLE_W-1:0]   adc_result;
    logic                  adc_start;
    logic [ADC_CH_W-1:0]   adc_channel;
    logic [WORD_W-1:0]     fifo_bus;
    logic                  data_fifo_enable;
    logic [PKT_LEN_W-1:0]  packet_len;
    logic                  end_of_data;
    logic                  xadc_busy;

    // Stimulus and expected data
    logic [SAMPLE_W-1:0]   sample_q[$];
    logic [SAMPLE_W-1:0]   pend_q[$];
    logic [SAMPLE_W-1:0]   adc_rec_q[$];
    logic [WORD_W-1:0]     exp_word_q[$];
    logic [PKT_LEN_W-1:0]  exp_len_q[$];
    logic                  exp_eod_q[$];

    logic [31:0]   sample_lcg = 32'd46602;
    logic [31:0]   lat_lcg    = 32'd46602;
    string         cur_name;
    int            cur_size;
    int            cur_delay;
    int            cur_nch;
    logic [2:0]    cur_chan;
    bit            run_active;
    int            cycle;
    int            done_cnt;
    int            done_base;
    int            last_done_cycle;
    int            adc_wait;
    int            word_idx;
    int            cmp_errors;
    int            mon_errors;
    int            task_errors;
    int            tests_run;
    bit            eod_check;
    bit            eod_low_check;
    logic          eod_next_exp;

    xadc_capture_top i_dut (
        .clk200           (clk200),
        .rst              (rst),
        .data_in_rdy      (data_in_rdy),
        .vmm_id           (vmm_id),
        .sample_size      (sample_size),
        .delay_in         (delay_in),
        .udp_done         (udp_done),
        .adc_done         (adc_done),
        .adc_result       (adc_result),
        .adc_start        (adc_start),
        .adc_channel      (adc_channel),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data),
        .xadc_busy        (xadc_busy)
    );

    always #5 clk200 = ~clk200;

    //////////////////////////////////////////////////
    // Cycle counter and timeout
    //////////////////////////////////////////////////
    always @(posedge clk200)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, run did not complete", cycle);
            $display("Simulation failed");
            $finish;
        end
    end

    // ADC model, 1 to 8 cycles per conversion
    always @(posedge clk200)
    begin
        adc_done <= 1'b0;
        if (adc_start)
        begin
            lat_lcg = lcg_next(lat_lcg);
            adc_wait <= 1 + int'(lat_lcg[18:16]);
        end
        else if (adc_wait > 0)
        begin
            adc_wait <= adc_wait - 1;
            if (adc_wait == 1)
            begin
                if (pend_q.size() == 0)
                begin
                    $display("%s: ADC asked for more samples than the run needs", cur_name);
                    mon_errors++;
                end
                else
                begin
                    adc_done   <= 1'b1;
                    adc_result <= pend_q[0];
                    adc_rec_q.push_back(pend_q.pop_front());
                end
            end
        end
    end

    // Request monitor: channel, spacing, and no start when idle
    always @(posedge clk200)
    begin
        int rel;
        int exp_ch;

        if (!rst)
        begin
            if (adc_done)
            begin
                done_cnt        <= done_cnt + 1;
                last_done_cycle <= cycle;
            end
            if (adc_start)
            begin
                rel    = done_cnt - done_base;
                exp_ch = (cur_nch > 1) ? rel / cur_size : int'(cur_chan);
                if (!run_active)
                begin
                    $display("%s: adc_start issued with no command pending", cur_name);
                    mon_errors++;
                end
                else if (int'(adc_channel) != exp_ch)
                begin
                    $display("[ERROR] %s: adc_channel expected %0d actual %0d",
                             cur_name, exp_ch, adc_channel);
                    mon_errors++;
                end
                if (run_active && rel > 0 && rel % cur_size != 0
                    && cycle - last_done_cycle != cur_delay + 2)
                begin
                    $display("[ERROR] %s: sample gap expected %0d actual %0d",
                             cur_name, cur_delay + 2, cycle - last_done_cycle);
                    mon_errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Compare process
    //////////////////////////////////////////////////
    always @(posedge clk200)
    begin
        logic [WORD_W-1:0]    ew;
        logic [PKT_LEN_W-1:0] el;
        logic                 ee;

        if (!rst)
        begin
            eod_check     <= 1'b0;
            eod_low_check <= eod_check;
            if (eod_check && end_of_data !== eod_next_exp)
            begin
                $display("[ERROR] %s: second end_of_data cycle expected %0b actual %0b",
                         cur_name, eod_next_exp, end_of_data);
                cmp_errors++;
            end
            if (eod_low_check && end_of_data !== 1'b0)
            begin
                $display("[ERROR] %s: third end_of_data cycle expected 0 actual %0b",
                         cur_name, end_of_data);
                cmp_errors++;
            end
            if (data_fifo_enable)
            begin
                if (exp_word_q.size() == 0)
                begin
                    $display("%s: extra word written to the FIFO", cur_name);
                    cmp_errors++;
                end
                else
                begin
                    ew = exp_word_q.pop_front();
                    el = exp_len_q.pop_front();
                    ee = exp_eod_q.pop_front();
                    if (fifo_bus !== ew)
                    begin
                        $display("[ERROR] %s: word %0d expected %h actual %h",
                                 cur_name, word_idx, ew, fifo_bus);
                        cmp_errors++;
                    end
                    if (packet_len !== el)
                    begin
                        $display("[ERROR] %s: word %0d packet_len expected %0d actual %0d",
                                 cur_name, word_idx, el, packet_len);
                        cmp_errors++;
                    end
                    if (end_of_data !== ee)
                    begin
                        $display("[ERROR] %s: word %0d end_of_data expected %0b actual %0b",
                                 cur_name, word_idx, ee, end_of_data);
                        cmp_errors++;
                    end
                    eod_check    <= 1'b1;
                    eod_next_exp <= ee;
                    word_idx     <= word_idx + 1;
                end
            end
        end
    end

    `include "tb_ref.svh"

    function automatic int error_total();
        return cmp_errors + mon_errors + task_errors;
    endfunction

    // One command from strobe to busy release
    task automatic run_test(input string name, input logic [15:0] vmm, input int size,
                            input int dly, input int nch, input logic [2:0] first,
                            input int hold);
        int total;
        int wait_cyc;
        int err_before;
        int words_before;

        err_before   = error_total();
        words_before = word_idx;
        cur_name     = name;
        cur_size     = size;
        cur_delay    = dly;
        cur_nch      = nch;
        cur_chan     = first;
        total        = size * nch;
        sample_q.delete();
        adc_rec_q.delete();
        for (int i = 0; i < total; i++)
        begin
            sample_lcg = lcg_next(sample_lcg);
            sample_q.push_back(sample_lcg[27:16]);
        end
        pend_q = sample_q;
        build_expected(first, nch, size);
        done_base  = done_cnt;
        run_active = 1'b1;

        @(posedge clk200);
        vmm_id      <= vmm;
        sample_size <= COUNT_W'(size);
        delay_in    <= DELAY_W'(dly);
        udp_done    <= 1'b0;
        data_in_rdy <= 1'b1;

        while (!xadc_busy)
            @(posedge clk200);
        while (done_cnt - done_base < total)
            @(posedge clk200);
        wait_cyc = 0;
        while (exp_word_q.size() != 0 && wait_cyc < 50)
        begin
            @(posedge clk200);
            wait_cyc++;
        end
        if (exp_word_q.size() != 0)
        begin
            $display("%s: %0d expected words never written", name, exp_word_q.size());
            task_errors++;
        end
        if (adc_rec_q.size() != total)
        begin
            $display("%s: ADC delivered the wrong number of samples", name);
            task_errors++;
        end

        // Busy must survive each release condition on its own
        udp_done <= 1'b1;
        repeat (hold) @(posedge clk200);
        if (!xadc_busy)
        begin
            $display("%s: xadc_busy fell while data_in_rdy was still high", name);
            task_errors++;
        end
        data_in_rdy <= 1'b0;
        udp_done    <= 1'b0;
        repeat (hold) @(posedge clk200);
        if (!xadc_busy)
        begin
            $display("%s: xadc_busy fell while udp_done was still low", name);
            task_errors++;
        end
        udp_done <= 1'b1;
        wait_cyc = 0;
        while (xadc_busy && wait_cyc < 10)
        begin
            @(posedge clk200);
            wait_cyc++;
        end
        if (xadc_busy || wait_cyc > 2)
        begin
            $display("%s: xadc_busy did not fall right after release", name);
            task_errors++;
        end
        run_active = 1'b0;
        repeat (20) @(posedge clk200);   // Idle, no requests allowed

        tests_run++;
        $display("%s: %0d words, %0d errors", name, word_idx - words_before,
                 error_total() - err_before);
    endtask

    initial
    begin
        clk200        = 1'b0;
        rst           = 1'b1;
        data_in_rdy   = 1'b0;
        vmm_id        = '0;
        sample_size   = '0;
        delay_in      = '0;
        udp_done      = 1'b0;
        adc_done      = 1'b0;
        adc_result    = '0;
        cycle         = 0;
        done_cnt      = 0;
        done_base     = 0;
        adc_wait      = 0;
        word_idx      = 0;
        cmp_errors    = 0;
        mon_errors    = 0;
        task_errors   = 0;
        tests_run     = 0;
        eod_check     = 1'b0;
        eod_low_check = 1'b0;
        run_active    = 1'b0;
        cur_name      = "reset";
        cur_size      = 1;
        cur_nch       = 1;
        cur_chan      = '0;

        repeat (10) @(posedge clk200);
        rst <= 1'b0;
        repeat (2) @(posedge clk200);

        run_test("single_channel", 16'd3, 7, 3, 1, 3'd2, 3);
        run_test("read_all", 16'd9, 3, 2, 8, 3'd0, 3);
        run_test("frame_cap", 16'd5, 760, 2, 1, 3'd4, 3);
        run_test("sample_delay", 16'd8, 6, 20, 1, 3'd7, 3);
        run_test("busy_release", 16'd1, 2, 1, 1, 3'd0, 30);

        $display("Tests run %0d, errors %0d", tests_run, error_total());
        if (error_total() == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_writer import xadc_pkg::*;
(
    input  wire logic                  clk200,
    input  wire logic                  rst,
    input  wire logic                  word_full,
    input  wire logic                  flush,
    input  wire logic [WORD_W-1:0]     pack_word,
    input  wire logic [WORD_CNT_W-1:0] word_count,
    output logic [WORD_W-1:0]          fifo_bus,
    output logic                       data_fifo_enable,
    output logic [PKT_LEN_W-1:0]       packet_len,
    output logic                       end_of_data,
    output logic                       word_taken,
    output logic                       frame_taken,
    output logic                       flush_done
);

    wr_state_t   state;
    logic        from_flush;    // Current write closes a channel
    logic        frame_end;

    assign frame_end = from_flush || (word_count == WORD_CNT_W'(MAX_WORDS_PER_FRAME));

    //////////////////////////////////////////////////
    // FIFO write FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state            <= WR_IDLE;
            from_flush       <= 1'b0;
            data_fifo_enable <= 1'b0;
            end_of_data      <= 1'b0;
            word_taken       <= 1'b0;
            frame_taken      <= 1'b0;
            flush_done       <= 1'b0;
        end
        else
        begin
            data_fifo_enable <= 1'b0;
            word_taken       <= 1'b0;
            frame_taken      <= 1'b0;
            flush_done       <= 1'b0;

            case (state)
                WR_IDLE:
                begin
                    if (word_full || flush)
                    begin
                        packet_len <= PKT_LEN_W'(word_count);
                        from_flush <= flush;
                        state      <= WR_WRITE;
                    end
                end

                WR_WRITE:
                begin
                    fifo_bus         <= pack_word;
                    data_fifo_enable <= 1'b1;
                    word_taken       <= 1'b1;  // Packer clears in the next cycle
                    flush_done       <= from_flush;
                    if (frame_end)
                    begin
                        end_of_data <= 1'b1;
                        frame_taken <= 1'b1;
                    end
                    state <= WR_CLEAR;
                end

                WR_CLEAR: state <= WR_HOLD;   // end_of_data kept for a second cycle

                WR_HOLD:
                begin
                    end_of_data <= 1'b0;
                    state       <= WR_IDLE;
                end

                default: state <= WR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/sample_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_sequencer import xadc_pkg::*;
(
    input  wire logic                  clk200,
    input  wire logic                  rst,
    input  wire logic                  data_in_rdy,
    input  wire logic [VMM_ID_W-1:0]   vmm_id,
    input  wire logic [COUNT_W-1:0]    sample_size,
    input  wire logic [DELAY_W-1:0]    delay_in,
    input  wire logic                  udp_done,
    input  wire logic                  adc_done,
    input  wire logic [SAMPLE_W-1:0]   adc_result,
    input  wire logic                  flush_done,
    output logic                       adc_start,
    output logic [ADC_CH_W-1:0]        adc_channel,
    output logic                       sample_valid,
    output logic [SAMPLE_W-1:0]        sample,
    output logic [CHAN_W-1:0]          chan_sel,
    output logic                       flush,
    output logic                       xadc_busy
);

    seq_state_t            state;
    logic                  data_in_rdy_d;
    logic                  read_all;
    logic                  flush_sent;
    logic [CHAN_W-1:0]     chan;
    logic [COUNT_W-1:0]    cnt;
    logic [COUNT_W-1:0]    cnt_inc;
    logic [DELAY_W-1:0]    dcnt;
    logic [VMM_ID_W-1:0]   vmm_m1;
    logic                  read_all_now;

    assign vmm_m1       = vmm_id - 1'b1;        // Chips are numbered from 1
    assign read_all_now = (vmm_m1[3:0] > 4'd7);
    assign cnt_inc      = cnt + 1'b1;

    assign adc_channel = {{(ADC_CH_W - CHAN_W){1'b0}}, chan};
    assign chan_sel    = chan;

    //////////////////////////////////////////////////
    // Run control FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state         <= SEQ_IDLE;
            data_in_rdy_d <= 1'b0;
            read_all      <= 1'b0;
            flush_sent    <= 1'b0;
            chan          <= '0;
            cnt           <= '0;
            dcnt          <= '0;
            adc_start     <= 1'b0;
            sample_valid  <= 1'b0;
            flush         <= 1'b0;
            xadc_busy     <= 1'b0;
        end
        else
        begin
            data_in_rdy_d <= data_in_rdy;
            adc_start     <= 1'b0;
            sample_valid  <= 1'b0;
            flush         <= 1'b0;

            case (state)
                SEQ_IDLE:
                begin
                    if (data_in_rdy && !data_in_rdy_d)    // New command
                    begin
                        xadc_busy <= 1'b1;
                        read_all  <= read_all_now;
                        chan      <= read_all_now ? '0 : vmm_m1[CHAN_W-1:0];
                        cnt       <= '0;
                        state     <= SEQ_REQUEST;
                    end
                end

                SEQ_REQUEST:
                begin
                    adc_start <= 1'b1;
                    state     <= SEQ_WAIT_ADC;
                end

                SEQ_WAIT_ADC:
                begin
                    if (adc_done)
                    begin
                        sample       <= adc_result;
                        sample_valid <= 1'b1;
                        cnt          <= cnt_inc;
                        dcnt         <= '0;
                        if (cnt_inc == sample_size)
                            state <= SEQ_FLUSH;           // Last sample of channel
                        else
                            state <= SEQ_DELAY;
                    end
                end

                // delay_in + 1 idle cycles, then the next request
                SEQ_DELAY:
                begin
                    if (dcnt == delay_in)
                    begin
                        adc_start <= 1'b1;
                        state     <= SEQ_WAIT_ADC;
                    end
                    else
                        dcnt <= dcnt + 1'b1;
                end

                SEQ_FLUSH:
                begin
                    if (!flush_sent)
                    begin
                        flush      <= 1'b1;
                        flush_sent <= 1'b1;
                    end
                    else if (flush_done)
                    begin
                        flush_sent <= 1'b0;
                        cnt        <= '0;
                        if (read_all && chan != CHAN_W'(NUM_CHANNELS - 1))
                        begin
                            chan  <= chan + 1'b1;
                            state <= SEQ_REQUEST;
                        end
                        else
                            state <= SEQ_WAIT_RELEASE;
                    end
                end

                // Old command gone and UDP frame sent
                SEQ_WAIT_RELEASE:
                begin
                    if (!data_in_rdy && udp_done)
                    begin
                        xadc_busy <= 1'b0;
                        state     <= SEQ_IDLE;
                    end
                end

                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/word_packer.sv
`timescale 1ns/1ps
`default_nettype none

module word_packer import xadc_pkg::*;
(
    input  wire logic                  clk200,
    input  wire logic                  rst,
    input  wire logic                  sample_valid,
    input  wire logic [SAMPLE_W-1:0]   sample,
    input  wire logic [CHAN_W-1:0]     chan_sel,
    input  wire logic                  word_taken,
    input  wire logic                  frame_taken,
    output logic [WORD_W-1:0]          pack_word,
    output logic                       word_full,
    output logic [WORD_CNT_W-1:0]      word_count
);

    logic [SLOT_W-1:0]       slot;
    logic [SLOT_W-1:0]       slot_next;
    logic [WORD_W-1:0]       word_next;
    logic [WORD_CNT_W-1:0]   count_next;
    logic                    full_next;

    // Clears from the writer apply first, so a sample
    // landing in the same cycle goes into a fresh word
    always_comb
    begin
        word_next  = word_taken ? '0 : pack_word;
        slot_next  = word_taken ? '0 : slot;
        count_next = frame_taken ? '0 : word_count;
        full_next  = 1'b0;

        if (sample_valid)
        begin
            if (slot_next == '0)
                count_next = count_next + 1'b1;     // Word starts here
            word_next[int'(slot_next) * SAMPLE_W +: SAMPLE_W] = sample;
            word_next[WORD_W-1 -: HDR_W] = {{(HDR_W - CHAN_W){1'b0}}, chan_sel};

            if (slot_next == SLOT_W'(SAMPLES_PER_WORD - 1))
            begin
                full_next = 1'b1;
                slot_next = '0;
            end
            else
                slot_next = slot_next + 1'b1;
        end
    end

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            pack_word  <= '0;   // Zero slots go out on partial words
            slot       <= '0;
            word_count <= '0;
            word_full  <= 1'b0;
        end
        else
        begin
            pack_word  <= word_next;
            slot       <= slot_next;
            word_count <= count_next;
            word_full  <= full_next;
        end
    end

endmodule

`default_nettype wire

//--- design/xadc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module xadc_capture_top import xadc_pkg::*;
(
    input  wire logic                  clk200,
    input  wire logic                  rst,
    input  wire logic                  data_in_rdy,
    input  wire logic [VMM_ID_W-1:0]   vmm_id,
    input  wire logic [COUNT_W-1:0]    sample_size,
    input  wire logic [DELAY_W-1:0]    delay_in,
    input  wire logic                  udp_done,
    input  wire logic                  adc_done,
    input  wire logic [SAMPLE_W-1:0]   adc_result,
    output logic                       adc_start,
    output logic [ADC_CH_W-1:0]        adc_channel,
    output logic [WORD_W-1:0]          fifo_bus,
    output logic                       data_fifo_enable,
    output logic [PKT_LEN_W-1:0]       packet_len,
    output logic                       end_of_data,
    output logic                       xadc_busy
);

    // Sequencer to packer and writer
    logic                    sample_valid;
    logic [SAMPLE_W-1:0]     sample;
    logic [CHAN_W-1:0]       chan_sel;
    logic                    flush;
    logic                    flush_done;

    // Packer and writer
    logic [WORD_W-1:0]       pack_word;
    logic                    word_full;
    logic [WORD_CNT_W-1:0]   word_count;
    logic                    word_taken;
    logic                    frame_taken;

    sample_sequencer i_sample_sequencer (
        .clk200       (clk200),
        .rst          (rst),
        .data_in_rdy  (data_in_rdy),
        .vmm_id       (vmm_id),
        .sample_size  (sample_size),
        .delay_in     (delay_in),
        .udp_done     (udp_done),
        .adc_done     (adc_done),
        .adc_result   (adc_result),
        .flush_done   (flush_done),
        .adc_start    (adc_start),
        .adc_channel  (adc_channel),
        .sample_valid (sample_valid),
        .sample       (sample),
        .chan_sel     (chan_sel),
        .flush        (flush),
        .xadc_busy    (xadc_busy)
    );

    word_packer i_word_packer (
        .clk200       (clk200),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .chan_sel     (chan_sel),
        .word_taken   (word_taken),
        .frame_taken  (frame_taken),
        .pack_word    (pack_word),
        .word_full    (word_full),
        .word_count   (word_count)
    );

    frame_writer i_frame_writer (
        .clk200           (clk200),
        .rst              (rst),
        .word_full        (word_full),
        .flush            (flush),
        .pack_word        (pack_word),
        .word_count       (word_count),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data),
        .word_taken       (word_taken),
        .frame_taken      (frame_taken),
        .flush_done       (flush_done)
    );

endmodule

`default_nettype wire

//--- design/xadc_pkg.sv
`default_nettype none

package xadc_pkg;

    //////////////////////////////////////////////////
    // Sample and word geometry
    //////////////////////////////////////////////////
    localparam int SAMPLE_W         = 12;    // One ADC result
    localparam int SAMPLES_PER_WORD = 5;
    localparam int WORD_W           = 64;    // FIFO bus word
    localparam int HDR_W            = WORD_W - SAMPLES_PER_WORD * SAMPLE_W;
    localparam int SLOT_W           = 3;     // Slot index inside a word

    // Channel selection
    localparam int CHAN_W       = 3;
    localparam int NUM_CHANNELS = 8;
    localparam int ADC_CH_W     = 5;         // ADC side channel address
    localparam int VMM_ID_W     = 16;

    //////////////////////////////////////////////////
    // Frame and run limits
    //////////////////////////////////////////////////
    localparam int MAX_WORDS_PER_FRAME = 150;
    localparam int WORD_CNT_W          = 9;
    localparam int PKT_LEN_W           = 12;
    localparam int COUNT_W             = 11; // Samples per channel
    localparam int DELAY_W             = 18; // Idle cycles between samples

    // Sequencer FSM
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_REQUEST,
        SEQ_WAIT_ADC,
        SEQ_DELAY,
        SEQ_FLUSH,
        SEQ_WAIT_RELEASE
    } seq_state_t;

    // Frame writer FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WRITE,
        WR_CLEAR,
        WR_HOLD
    } wr_state_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_xadc_capture \
    -f xadc_capture.f \
    -o sim_xadc_capture

out=$(./obj_dir/sim_xadc_capture)
echo "$out"
echo "$out" | grep -q "Simulation passed"

//--- xadc_capture.f
+incdir+bench
design/xadc_pkg.sv
design/sample_sequencer.sv
design/word_packer.sv
design/frame_writer.sv
design/xadc_capture_top.sv
bench/tb_xadc_capture.sv
